// ==== sim.f ====
design/frame_reader_pkg.sv
design/scale_1d.sv
design/line_reader.sv
design/line_buffer.sv
design/line_sequencer.sv
design/frame_reader.sv
bench/tb_frame_reader.sv

// ==== bench/tb_frame_reader.sv ====
`timescale 1ns/1ps

module tb_frame_reader;
	import frame_reader_pkg::*;

	localparam int frame_count = 6;
	localparam int cycle_limit = frame_count * 2000;

	logic clk;
	logic resetn;
	logic fsync;
	logic [addr_width-1:0] frame_addr;
	win_geom_t geom;
	logic [addr_width-1:0] araddr;
	logic [7:0] arlen;
	logic arvalid;
	logic arready;
	logic [axi_data_width-1:0] rdata;
	logic rlast;
	logic rvalid;
	logic rready;
	logic tvalid;
	pix_out_t tdata;
	logic tready;
	logic frame_done;

	string test_name;
	logic stall_mode;
	int cycle_count;
	int done_count;
	int mem_beats;
	int mem_beat;
	int mem_wait;
	logic beat_taken;
	logic [addr_width-1:0] mem_addr;
	pix_out_t beats_seen[$];
	pix_out_t beats_free[$];

	frame_reader UUT (
		.clk(clk),
		.resetn(resetn),
		.fsync(fsync),
		.frame_addr(frame_addr),
		.geom(geom),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready),
		.tvalid(tvalid),
		.tdata(tdata),
		.tready(tready),
		.frame_done(frame_done)
	);

	always #50 clk = ~clk;

	// byte folds every address bit, so rows and frames never alias
	function automatic logic [7:0] byte_at(input logic [addr_width-1:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
	endfunction

	function automatic logic [axi_data_width-1:0] mem_word(input logic [addr_width-1:0] a);
		logic [axi_data_width-1:0] w;
		int j;
		for (j = 0; j < word_bytes; j++)
			w[8*j +: 8] = byte_at(a + j);
		return w;
	endfunction

	function automatic win_geom_t make_geom(input int left, input int top, input int ww,
		input int wh, input int dw, input int dh);
		win_geom_t g;
		g.img_width = img_wbits'(640);
		g.img_height = img_hbits'(480);
		g.win_left = img_wbits'(left);
		g.win_top = img_hbits'(top);
		g.win_width = img_wbits'(ww);
		g.win_height = img_hbits'(wh);
		g.dst_width = img_wbits'(dw);
		g.dst_height = img_hbits'(dh);
		return g;
	endfunction

	// AXI read slave, random latency before each burst, then back to back beats
	always begin
		@(posedge clk);
		#5;
		if (resetn && arvalid) begin
			mem_addr = araddr;
			mem_beats = arlen + 1;
			arready = 1'b1;
			@(posedge clk);
			#5;
			arready = 1'b0;
			mem_wait = $urandom_range(3, 0);
			repeat (mem_wait) begin
				@(posedge clk);
				#5;
			end
			for (mem_beat = 0; mem_beat < mem_beats; mem_beat++) begin
				rvalid = 1'b1;
				rdata = mem_word(mem_addr + word_bytes * mem_beat);
				rlast = (mem_beat == mem_beats - 1);
				// a beat only moves on when the reader takes it
				do begin
					beat_taken = rready;
					@(posedge clk);
					#5;
				end while (!beat_taken);
			end
			rvalid = 1'b0;
			rlast = 1'b0;
		end
	end

	// stream sink, random back-pressure when stalls are on
	always begin
		@(posedge clk);
		#5;
		tready = stall_mode ? ($urandom_range(2, 0) != 0) : 1'b1;
	end

	// every stream handshake is logged, extra beats included
	always @(negedge clk) begin
		if (resetn && tvalid && tready)
			beats_seen.push_back(tdata);
	end

	always @(negedge clk) begin
		if (frame_done)
			done_count++;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: stream did not complete within %0d cycles", cycle_limit);
			$display("** FAIL **");
			$fatal(1);
		end
	end

	task automatic check_value(input string field, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s %s: expected %0h, actual %0h", test_name, field,
				expected, actual);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	// one frame, every beat checked against the nearest neighbour rule
	task automatic run_frame(input win_geom_t g, input logic [addr_width-1:0] base);
		int x;
		int y;
		int sx;
		int sy;
		pix_out_t beat;
		beats_seen.delete();
		done_count = 0;
		geom = g;
		frame_addr = base;
		fsync = 1'b1;
		@(posedge clk);
		#5;
		fsync = 1'b0;
		for (y = 0; y < g.dst_height; y++) begin
			sy = y * g.win_height / g.dst_height + g.win_top;
			for (x = 0; x < g.dst_width; x++) begin
				sx = x * g.win_width / g.dst_width + g.win_left;
				// handshake happens on the coming rising edge
				do
					@(negedge clk);
				while (!(tvalid && tready));
				beat = tdata;
				check_value("data", byte_at(base + sy * stride + sx), beat.data);
				check_value("source_x", sx, beat.source_x);
				check_value("source_y", sy, beat.source_y);
				check_value("tuser", (x == 0 && y == 0), beat.user);
				check_value("tlast", (x == g.dst_width - 1), beat.last);
			end
		end
		repeat (4) @(posedge clk);
		#5;
		check_value("frame_done count", 1, done_count);
	endtask

	task automatic identity_test();
		test_name = "identity";
		run_frame(make_geom(0, 0, 8, 2, 8, 2), 32'h0001_0000);
	endtask

	task automatic unaligned_crop_test();
		test_name = "unaligned crop";
		run_frame(make_geom(5, 3, 10, 2, 10, 2), 32'h0002_0000);
	endtask

	task automatic upscale_test();
		test_name = "upscale";
		run_frame(make_geom(20, 7, 4, 2, 8, 4), 32'h0005_0000);
	endtask

	task automatic downscale_test();
		test_name = "downscale";
		run_frame(make_geom(32, 0, 16, 1, 4, 1), 32'h0006_0000);
	endtask

	// two bursts per line and three rows, so both buffers fill
	task automatic stall_test();
		int i;
		test_name = "tready stalls";
		stall_mode = 1'b0;
		run_frame(make_geom(2, 1, 24, 3, 12, 3), 32'h0003_4500);
		beats_free = beats_seen;
		stall_mode = 1'b1;
		run_frame(make_geom(2, 1, 24, 3, 12, 3), 32'h0003_4500);
		stall_mode = 1'b0;
		check_value("beat count", beats_free.size(), beats_seen.size());
		for (i = 0; i < beats_free.size(); i++)
			check_value("beat", beats_free[i], beats_seen[i]);
	endtask

	initial begin
		void'($urandom(32'hd1ac95b2));
		clk = 1'b0;
		resetn = 1'b0;
		fsync = 1'b0;
		frame_addr = '0;
		geom = '0;
		arready = 1'b0;
		rdata = '0;
		rlast = 1'b0;
		rvalid = 1'b0;
		tready = 1'b1;
		stall_mode = 1'b0;
		cycle_count = 0;
		done_count = 0;
		repeat (4) @(posedge clk);
		#5;
		resetn = 1'b1;
		repeat (2) @(posedge clk);
		#5;
		identity_test();
		unaligned_crop_test();
		upscale_test();
		downscale_test();
		stall_test();
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== design/frame_reader.sv ====
`timescale 1ns/1ps

module frame_reader (
	input  logic clk,
	input  logic resetn,
	input  logic fsync,
	input  logic [frame_reader_pkg::addr_width-1:0] frame_addr,
	input  frame_reader_pkg::win_geom_t geom,
	output logic [frame_reader_pkg::addr_width-1:0] araddr,
	output logic [7:0] arlen,
	output logic arvalid,
	input  logic arready,
	input  logic [frame_reader_pkg::axi_data_width-1:0] rdata,
	input  logic rlast,
	input  logic rvalid,
	output logic rready,
	output logic tvalid,
	output frame_reader_pkg::pix_out_t tdata,
	input  logic tready,
	output logic frame_done
);
	import frame_reader_pkg::*;

	logic [addr_width-1:0] frame_offset;
	logic [img_wbits-1:0] fetch_words;
	logic [burst_sel_bits-1:0] read_offset;
	logic [img_wbits-1:0] head_width;
	logic sof_start;
	logic line_valid;
	logic line_ready;
	logic fetch_idle;
	logic [img_hbits-1:0] row_index;
	logic [img_hbits-1:0] row_y;
	logic [addr_width-1:0] line_addr;
	line_req_t line_req;
	buf_write_t wr;
	logic eol_write;
	logic wr_sel;
	logic rd_sel;
	logic start_line;
	logic pix_valid;
	logic pix_ready;
	logic pix_last;
	logic [img_wbits-1:0] pix_x;
	logic [addr_width-1:0] pix_addr;
	logic [pixel_width-1:0] rd_data;

	// fetch starts at the burst boundary below win_left, so count its head too
	assign head_width = {{(img_wbits-burst_sel_bits){1'b0}}, geom.win_left[burst_sel_bits-1:0]}
		+ geom.win_width + img_wbits'(word_pixels - 1);

	always_ff @(posedge clk) begin
		if (fsync) begin
			frame_offset <= addr_width'({geom.win_left[img_wbits-1:burst_sel_bits],
				{burst_sel_bits{1'b0}}}) + addr_width'(geom.win_top) * addr_width'(stride);
			fetch_words <= head_width >> word_sel_bits;
			read_offset <= geom.win_left[burst_sel_bits-1:0];
		end
	end

	scale_1d height_scaler (
		.clk(clk),
		.resetn(resetn),
		.start(sof_start),
		.src_len(geom.win_height),
		.dst_len(geom.dst_height),
		.base_addr(frame_addr + frame_offset),
		.inc_addr(addr_width'(stride)),
		.o_ready(line_ready),
		.o_valid(line_valid),
		.o_last(),
		.s_index(row_index),
		.s_addr(line_addr)
	);

	assign line_req = '{addr: line_addr, words: fetch_words};
	assign row_y = row_index + geom.win_top;

	line_reader reader (
		.clk(clk),
		.resetn(resetn),
		.req(line_req),
		.req_valid(line_valid && line_ready),
		.req_ready(fetch_idle),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready),
		.wr(wr),
		.eol_write(eol_write)
	);

	line_buffer buffers (
		.clk(clk),
		.wr(wr),
		.wr_sel(wr_sel),
		.rd_en(pix_valid && pix_ready),
		.rd_sel(rd_sel),
		.rd_addr(pix_addr[img_wbits-1:0]),
		.rd_data(rd_data)
	);

	// column addresses are relative to the first fetched word
	scale_1d width_scaler (
		.clk(clk),
		.resetn(resetn),
		.start(start_line),
		.src_len(geom.win_width),
		.dst_len(geom.dst_width),
		.base_addr(addr_width'(read_offset)),
		.inc_addr(addr_width'(1)),
		.o_ready(pix_ready),
		.o_valid(pix_valid),
		.o_last(pix_last),
		.s_index(pix_x),
		.s_addr(pix_addr)
	);

	line_sequencer sequencer (
		.clk(clk),
		.resetn(resetn),
		.fsync(fsync),
		.eol_write(eol_write),
		.line_valid(line_valid),
		.line_ready_in(fetch_idle),
		.pix_valid(pix_valid),
		.pix_last(pix_last),
		.source_x(pix_x),
		.source_y(row_y),
		.win_left(geom.win_left),
		.rd_data(rd_data),
		.tready(tready),
		.sof_start(sof_start),
		.line_ready(line_ready),
		.wr_sel(wr_sel),
		.rd_sel(rd_sel),
		.start_line(start_line),
		.pix_ready(pix_ready),
		.tvalid(tvalid),
		.tdata(tdata),
		.frame_done(frame_done)
	);

endmodule

// ==== design/line_sequencer.sv ====
`timescale 1ns/1ps

module line_sequencer (
	input  logic clk,
	input  logic resetn,
	input  logic fsync,
	input  logic eol_write,
	input  logic line_valid,
	input  logic line_ready_in,
	input  logic pix_valid,
	input  logic pix_last,
	input  logic [frame_reader_pkg::img_wbits-1:0] source_x,
	input  logic [frame_reader_pkg::img_hbits-1:0] source_y,
	input  logic [frame_reader_pkg::img_wbits-1:0] win_left,
	input  logic [frame_reader_pkg::pixel_width-1:0] rd_data,
	input  logic tready,
	output logic sof_start,
	output logic line_ready,
	output logic wr_sel,
	output logic rd_sel,
	output logic start_line,
	output logic pix_ready,
	output logic tvalid,
	output frame_reader_pkg::pix_out_t tdata,
	output logic frame_done
);
	import frame_reader_pkg::*;

	logic [buf_count-1:0] buf_full;
	logic [buf_count-1:0] wr_hot;
	logic [buf_count-1:0] rd_hot;
	logic [img_hbits-1:0] buf_row [buf_count];
	logic reading;
	logic eol_read;
	logic pix_fire;
	logic [img_wbits-1:0] out_x;
	logic [img_hbits-1:0] out_y;
	logic out_user;
	logic out_last;

	// window offsets are latched on fsync, the scaler starts one cycle later
	always_ff @(posedge clk) begin
		if (!resetn)
			sof_start <= 1'b0;
		else
			sof_start <= fsync;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_hot <= '0;
			rd_hot <= '0;
		end else if (fsync) begin
			wr_hot <= buf_count'(1);
			rd_hot <= buf_count'(1);
		end else begin
			if (eol_write)
				wr_hot <= {wr_hot[buf_count-2:0], wr_hot[buf_count-1]};
			if (eol_read)
				rd_hot <= {rd_hot[buf_count-2:0], rd_hot[buf_count-1]};
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			buf_full <= '0;
		end else if (fsync) begin
			buf_full <= '0;
		end else begin
			for (int i = 0; i < buf_count; i++) begin
				if (eol_write && wr_hot[i])
					buf_full[i] <= 1'b1;
				else if (eol_read && rd_hot[i])
					buf_full[i] <= 1'b0;
			end
		end
	end

	assign wr_sel = wr_hot[1];
	assign rd_sel = rd_hot[1];
	assign line_ready = line_ready_in && ((wr_hot & buf_full) == '0);

	// remember which source row went into each buffer
	always_ff @(posedge clk) begin
		for (int i = 0; i < buf_count; i++) begin
			if (line_valid && line_ready && wr_hot[i])
				buf_row[i] <= source_y;
		end
	end

	// no line pending when the final fetch completes
	assign frame_done = eol_write && !line_valid;

	always_ff @(posedge clk) begin
		if (!resetn)
			eol_read <= 1'b0;
		else
			eol_read <= tvalid && tready && out_last;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			start_line <= 1'b0;
			reading <= 1'b0;
		end else if (fsync) begin
			start_line <= 1'b0;
			reading <= 1'b0;
		end else begin
			start_line <= !start_line && !reading && ((buf_full & rd_hot) != '0);
			if (start_line)
				reading <= 1'b1;
			else if (eol_read)
				reading <= 1'b0;
		end
	end

	// output register stage, stalls the width scaler on back-pressure
	assign pix_ready = reading && (!tvalid || tready);
	assign pix_fire = pix_valid && pix_ready;

	always_ff @(posedge clk) begin
		if (!resetn)
			tvalid <= 1'b0;
		else if (pix_fire)
			tvalid <= 1'b1;
		else if (tready)
			tvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			out_user <= 1'b0;
		else if (fsync)
			out_user <= 1'b1;
		else if (tvalid && tready)
			out_user <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (pix_fire) begin
			out_x <= source_x + win_left;
			out_y <= buf_row[rd_sel];
			out_last <= pix_last;
		end
	end

	// pixel data comes straight from the buffer read register
	assign tdata = '{data: rd_data, source_x: out_x, source_y: out_y,
		user: out_user, last: out_last};

	buf_hot_onehot: assert property (@(posedge clk) disable iff (!resetn)
		(fsync || ($onehot(wr_hot) && $onehot(rd_hot)))
		|=> ($onehot(wr_hot) && $onehot(rd_hot)));

endmodule

// ==== design/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer (
	input  logic clk,
	input  frame_reader_pkg::buf_write_t wr,
	input  logic wr_sel,
	input  logic rd_en,
	input  logic rd_sel,
	input  logic [frame_reader_pkg::img_wbits-1:0] rd_addr,
	output logic [frame_reader_pkg::pixel_width-1:0] rd_data
);
	import frame_reader_pkg::*;

	logic rd_sel_q;
	logic [word_sel_bits-1:0] lane_q;
	logic [axi_data_width-1:0] word_q;

	// one RAM per buffer, written by word and read by pixel
	for (genvar b = 0; b < buf_count; b++) begin : g_bank
		logic [axi_data_width-1:0] mem [buf_words];
		logic [axi_data_width-1:0] rd_word;

		always_ff @(posedge clk) begin
			if (wr.en && wr_sel == 1'(b))
				mem[wr.addr] <= wr.data;
		end

		always_ff @(posedge clk) begin
			if (rd_en && rd_sel == 1'(b))
				rd_word <= mem[rd_addr[img_wbits-1:word_sel_bits]];
		end
	end

	// lane and bank select follow the read, so the output holds between reads
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_sel_q <= rd_sel;
			lane_q <= rd_addr[word_sel_bits-1:0];
		end
	end

	assign word_q = rd_sel_q ? g_bank[1].rd_word : g_bank[0].rd_word;

	// little endian, pixel 0 sits in the low byte
	assign rd_data = word_q[lane_q*pixel_width +: pixel_width];

endmodule

// ==== design/line_reader.sv ====
`timescale 1ns/1ps

module line_reader (
	input  logic clk,
	input  logic resetn,
	input  frame_reader_pkg::line_req_t req,
	input  logic req_valid,
	output logic req_ready,
	output logic [frame_reader_pkg::addr_width-1:0] araddr,
	output logic [7:0] arlen,
	output logic arvalid,
	input  logic arready,
	input  logic [frame_reader_pkg::axi_data_width-1:0] rdata,
	input  logic rlast,
	input  logic rvalid,
	output logic rready,
	output frame_reader_pkg::buf_write_t wr,
	output logic eol_write
);
	import frame_reader_pkg::*;

	logic busy;
	logic beat;
	logic [img_wbits-1:0] words_left;
	logic [7:0] beat_cnt;
	logic [7:0] burst_last;
	logic [wr_index_bits-1:0] wr_addr;

	assign beat = rvalid && rready;
	// busy drops one cycle after eol_write, once the buffer flags have moved
	assign req_ready = !busy;

	// words_left only moves on the AR handshake, so arlen holds while arvalid
	assign arlen = (words_left >= img_wbits'(burst_len)) ? 8'(burst_len - 1)
		: 8'(words_left - 1'b1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			arvalid <= 1'b0;
			rready <= 1'b0;
			eol_write <= 1'b0;
		end else begin
			eol_write <= 1'b0;
			if (eol_write)
				busy <= 1'b0;
			if (req_valid && req_ready) begin
				busy <= 1'b1;
				arvalid <= 1'b1;
			end
			if (arvalid && arready) begin
				arvalid <= 1'b0;
				rready <= 1'b1;
			end
			if (beat && rlast) begin
				rready <= 1'b0;
				// either the line is complete or the next burst goes out
				if (words_left == '0)
					eol_write <= 1'b1;
				else
					arvalid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			araddr <= req.addr;
			words_left <= req.words;
			wr_addr <= '0;
		end
		if (arvalid && arready) begin
			araddr <= araddr + addr_width'(burst_len * word_bytes);
			words_left <= words_left - (img_wbits'(arlen) + 1'b1);
			burst_last <= arlen;
			beat_cnt <= '0;
		end
		if (beat) begin
			wr_addr <= wr_addr + 1'b1;
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// each beat lands at the next word of the line buffer
	assign wr = '{en: beat, addr: wr_addr, data: rdata};

	// memory must end every burst on the beat count it was asked for
	rlast_on_count: assert property (@(posedge clk) disable iff (!resetn)
		beat |-> (rlast == (beat_cnt == burst_last)));

endmodule

// ==== design/scale_1d.sv ====
`timescale 1ns/1ps

module scale_1d (
	input  logic clk,
	input  logic resetn,
	input  logic start,
	input  logic [frame_reader_pkg::img_wbits-1:0] src_len,
	input  logic [frame_reader_pkg::img_wbits-1:0] dst_len,
	input  logic [frame_reader_pkg::addr_width-1:0] base_addr,
	input  logic [frame_reader_pkg::addr_width-1:0] inc_addr,
	input  logic o_ready,
	output logic o_valid,
	output logic o_last,
	output logic [frame_reader_pkg::img_wbits-1:0] s_index,
	output logic [frame_reader_pkg::addr_width-1:0] s_addr
);
	import frame_reader_pkg::*;

	logic busy;
	logic [div_cnt_bits-1:0] div_cnt;
	// holds the dividend while busy, the quotient (step) afterwards
	logic [step_bits-1:0] div_num;
	logic [img_wbits:0] div_rem;
	logic [img_wbits:0] rem_shift;
	logic [step_bits-1:0] pos;
	logic [img_wbits-1:0] pos_rem;
	logic [img_wbits:0] rem_sum;
	logic [img_wbits:0] rem_wrap;
	logic [img_wbits-1:0] out_cnt;

	assign rem_shift = {div_rem[img_wbits-1:0], div_num[step_bits-1]};

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			div_cnt <= '0;
		end else if (start) begin
			busy <= 1'b1;
			div_cnt <= '0;
		end else if (busy) begin
			div_cnt <= div_cnt + 1'b1;
			if (div_cnt == div_cnt_bits'(step_bits - 1))
				busy <= 1'b0;
		end
	end

	// restoring division, one quotient bit per cycle
	always_ff @(posedge clk) begin
		if (start) begin
			div_num <= {src_len, {frac_bits{1'b0}}};
			div_rem <= '0;
		end else if (busy) begin
			if (rem_shift >= {1'b0, dst_len}) begin
				div_rem <= rem_shift - {1'b0, dst_len};
				div_num <= {div_num[step_bits-2:0], 1'b1};
			end else begin
				div_rem <= rem_shift;
				div_num <= {div_num[step_bits-2:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			o_valid <= 1'b0;
		else if (start)
			o_valid <= 1'b0;
		else if (busy && div_cnt == div_cnt_bits'(step_bits - 1))
			o_valid <= 1'b1;
		else if (o_valid && o_ready && o_last)
			o_valid <= 1'b0;
	end

	// the remainder carry keeps the index exactly floor(k*src/dst)
	assign rem_sum = {1'b0, pos_rem} + div_rem;
	assign rem_wrap = rem_sum - {1'b0, dst_len};

	always_ff @(posedge clk) begin
		if (busy) begin
			pos <= '0;
			pos_rem <= '0;
			out_cnt <= '0;
		end else if (o_valid && o_ready) begin
			out_cnt <= out_cnt + 1'b1;
			if (rem_sum >= {1'b0, dst_len}) begin
				pos_rem <= rem_wrap[img_wbits-1:0];
				pos <= pos + div_num + 1'b1;
			end else begin
				pos_rem <= rem_sum[img_wbits-1:0];
				pos <= pos + div_num;
			end
		end
	end

	assign o_last = (out_cnt == dst_len - 1'b1);
	assign s_index = pos[step_bits-1:frac_bits];
	assign s_addr = base_addr + {{(addr_width-img_wbits){1'b0}}, s_index} * inc_addr;

	// first output only appears as the division finishes
	valid_after_div: assert property (@(posedge clk) disable iff (!resetn)
		$rose(o_valid) |-> !busy && $past(busy));

endmodule

// ==== design/frame_reader_pkg.sv ====
package frame_reader_pkg;

	// data path widths
	localparam int pixel_width = 8;
	localparam int addr_width = 32;
	localparam int axi_data_width = 32;
	localparam int img_wbits = 12;
	localparam int img_hbits = 12;

	// memory and line geometry
	localparam int burst_len = 4;
	localparam int stride = 1024;
	localparam int word_pixels = 4;
	localparam int burst_pixels = 16;
	localparam int wr_index_bits = 10;
	localparam int frac_bits = 8;

	// derived sizes
	localparam int word_bytes = axi_data_width / 8;
	localparam int word_sel_bits = $clog2(word_pixels);
	localparam int burst_sel_bits = $clog2(burst_pixels);
	localparam int buf_count = 2;
	localparam int buf_words = 1 << wr_index_bits;
	// scaler step is integer.fraction of a source index
	localparam int step_bits = img_wbits + frac_bits;
	localparam int div_cnt_bits = $clog2(step_bits);

	// crop window inside the frame and the scaled output size
	typedef struct packed {
		logic [img_wbits-1:0] img_width;
		logic [img_hbits-1:0] img_height;
		logic [img_wbits-1:0] win_left;
		logic [img_hbits-1:0] win_top;
		logic [img_wbits-1:0] win_width;
		logic [img_hbits-1:0] win_height;
		logic [img_wbits-1:0] dst_width;
		logic [img_hbits-1:0] dst_height;
	} win_geom_t;

	// one source line to fetch, starting at a burst aligned byte address
	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [img_wbits-1:0] words;
	} line_req_t;

	typedef struct packed {
		logic en;
		logic [wr_index_bits-1:0] addr;
		logic [axi_data_width-1:0] data;
	} buf_write_t;

	// stream beat, user marks start of frame and last marks end of line
	typedef struct packed {
		logic [pixel_width-1:0] data;
		logic [img_wbits-1:0] source_x;
		logic [img_hbits-1:0] source_y;
		logic user;
		logic last;
	} pix_out_t;

endpackage
